// ==== hdl/pm_defines.svh ====
`ifndef PM_DEFINES_SVH
`define PM_DEFINES_SVH

// Metric format
`define PM_WIDTH        9
`define PM_NUM_STATES   64
`define PM_STATE_BITS   6

// Lower clamp, also the start value of states other than 0
`define PM_SAT_MIN      -128

// ------------------------------
// Register access
// ------------------------------
`define PM_AXIL_ADDR_W  4
`define PM_AXIL_DATA_W  32

// Byte addresses
`define PM_REG_CFG      4'h0
`define PM_REG_STATUS   4'h4

`endif

// ==== hdl/pm_pkg.sv ====
package pm_pkg;

    `include "pm_defines.svh"

    typedef logic signed [`PM_WIDTH-1:0] pm_metric_t;
    typedef pm_metric_t [`PM_NUM_STATES-1:0] pm_vec_t;
    typedef logic [`PM_STATE_BITS-1:0] pm_state_t;

    typedef struct packed {
        pm_metric_t metric;
        pm_state_t  state;
    } pm_winner_t;

    // Number of active states
    typedef enum logic [1:0] {
        PM_MODE_64 = 2'd0,
        PM_MODE_32 = 2'd1,
        PM_MODE_16 = 2'd2,
        PM_MODE_8  = 2'd3
    } pm_mode_e;

    typedef struct packed {
        logic [`PM_NUM_STATES-1:0] mask;
        logic                      tail_biting;
    } pm_cfg_t;

    // ------------------------------
    // AXI4-Lite channels
    // ------------------------------
    typedef struct packed {
        logic                        awvalid;
        logic [`PM_AXIL_ADDR_W-1:0]  awaddr;
        logic                        wvalid;
        logic [`PM_AXIL_DATA_W-1:0]  wdata;
        logic [`PM_AXIL_DATA_W/8-1:0] wstrb;
        logic                        bready;
        logic                        arvalid;
        logic [`PM_AXIL_ADDR_W-1:0]  araddr;
        logic                        rready;
    } axil_req_t;

    typedef struct packed {
        logic                        awready;
        logic                        wready;
        logic                        bvalid;
        logic [1:0]                  bresp;
        logic                        arready;
        logic                        rvalid;
        logic [`PM_AXIL_DATA_W-1:0]  rdata;
        logic [1:0]                  rresp;
    } axil_rsp_t;

endpackage

// ==== hdl/pm_cfg_regs.sv ====
`timescale 1ns/100ps
`include "pm_defines.svh"

module pm_cfg_regs (
    input  logic                clk_i,
    input  logic                rst_an_i,
    input  pm_pkg::axil_req_t   axil_req_i,
    output pm_pkg::axil_rsp_t   axil_rsp_o,
    input  pm_pkg::pm_state_t   max_state_i,
    output pm_pkg::pm_cfg_t     cfg_o
);

    import pm_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [`PM_NUM_STATES-1:0] ALL_STATES = '1;

    pm_mode_e                    mode_q;
    logic                        tail_biting_q;
    logic                        wr_rdy_q;
    logic                        bvalid_q;
    logic                        rd_rdy_q;
    logic                        rvalid_q;
    logic [`PM_AXIL_DATA_W-1:0]  rdata_q;
    logic [`PM_AXIL_DATA_W-1:0]  rd_word;
    logic                        wr_start;
    logic                        rd_start;

    // Only one transaction of each kind in flight
    assign wr_start = axil_req_i.awvalid & axil_req_i.wvalid & ~wr_rdy_q & ~bvalid_q;
    assign rd_start = axil_req_i.arvalid & ~rd_rdy_q & ~rvalid_q;

    // ------------------------------
    // Write channel
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            wr_rdy_q      <= 1'b0;
            bvalid_q      <= 1'b0;
            mode_q        <= PM_MODE_64;
            tail_biting_q <= 1'b0;
        end else begin
            wr_rdy_q <= wr_start;
            if (wr_rdy_q) begin
                bvalid_q <= 1'b1;
                // STATUS is read-only, writes there fall through
                if (axil_req_i.awaddr == `PM_REG_CFG && axil_req_i.wstrb[0]) begin
                    mode_q        <= pm_mode_e'(axil_req_i.wdata[1:0]);
                    tail_biting_q <= axil_req_i.wdata[4];
                end
            end else if (bvalid_q && axil_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // ------------------------------
    // Read channel
    // ------------------------------
    always_comb begin
        rd_word = '0;
        case (axil_req_i.araddr)
            `PM_REG_CFG: begin
                rd_word[1:0] = mode_q;
                rd_word[4]   = tail_biting_q;
            end
            `PM_REG_STATUS: rd_word[`PM_STATE_BITS-1:0] = max_state_i;
            default:        rd_word = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            rd_rdy_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            rd_rdy_q <= rd_start;
            if (rd_rdy_q) begin
                rvalid_q <= 1'b1;
            end else if (rvalid_q && axil_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // Addressed word captured with arready
    always_ff @(posedge clk_i) begin
        if (rd_rdy_q) begin
            rdata_q <= rd_word;
        end
    end

    always_comb begin
        axil_rsp_o.awready = wr_rdy_q;
        axil_rsp_o.wready  = wr_rdy_q;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.bresp   = RESP_OKAY;
        axil_rsp_o.arready = rd_rdy_q;
        axil_rsp_o.rvalid  = rvalid_q;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = RESP_OKAY;
    end

    // Mode to contiguous mask from state 0
    always_comb begin
        case (mode_q)
            PM_MODE_32: cfg_o.mask = ALL_STATES >> (`PM_NUM_STATES / 2);
            PM_MODE_16: cfg_o.mask = ALL_STATES >> (`PM_NUM_STATES * 3 / 4);
            PM_MODE_8:  cfg_o.mask = ALL_STATES >> (`PM_NUM_STATES * 7 / 8);
            default:    cfg_o.mask = ALL_STATES;
        endcase
        cfg_o.tail_biting = tail_biting_q;
    end

    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rst_an_i)
        axil_rsp_o.bvalid && !axil_req_i.bready |=> axil_rsp_o.bvalid);

endmodule

// ==== hdl/pm_max_tree.sv ====
`timescale 1ns/100ps
`include "pm_defines.svh"

module pm_max_tree (
    input  pm_pkg::pm_vec_t     pm_i,
    input  pm_pkg::pm_cfg_t     cfg_i,
    output pm_pkg::pm_winner_t  winner_o
);

    import pm_pkg::*;

    localparam int LEVELS = $clog2(`PM_NUM_STATES);

    genvar l, j;

    // Level 0 holds the leaves, each later level halves the count
    for (l = 0; l <= LEVELS; l++) begin : g_lvl
        localparam int N = `PM_NUM_STATES >> l;

        pm_winner_t win [N];
        logic       vld [N];

        if (l == 0) begin : g_leaf
            for (j = 0; j < N; j++) begin : g_st
                assign win[j].metric = pm_i[j];
                assign win[j].state  = pm_state_t'(j);
                // Masked-off states drop out of the search
                assign vld[j]        = cfg_i.mask[j];
            end
        end else begin : g_cmp
            for (j = 0; j < N; j++) begin : g_pair
                pm_winner_t lo;
                pm_winner_t hi;
                logic       take_hi;

                assign lo = g_lvl[l-1].win[2*j];
                assign hi = g_lvl[l-1].win[2*j+1];

                // Upper half must be strictly larger, ties stay low
                assign take_hi = g_lvl[l-1].vld[2*j+1] &&
                                 (!g_lvl[l-1].vld[2*j] ||
                                  $signed(hi.metric) > $signed(lo.metric));

                assign win[j] = take_hi ? hi : lo;
                assign vld[j] = g_lvl[l-1].vld[2*j] | g_lvl[l-1].vld[2*j+1];
            end
        end
    end

    assign winner_o = g_lvl[LEVELS].win[0];

    always_comb begin
        a_winner_active: assert final (g_lvl[LEVELS].vld[0] && cfg_i.mask[winner_o.state]);
    end

endmodule

// ==== hdl/pm_normalizer.sv ====
`timescale 1ns/100ps
`include "pm_defines.svh"

module pm_normalizer (
    input  logic                clk_i,
    input  logic                rst_an_i,
    input  logic                rst_sync_i,
    input  logic                frame_start_i,
    input  logic                en_i,
    input  pm_pkg::pm_vec_t     pm_i,
    input  pm_pkg::pm_cfg_t     cfg_i,
    input  pm_pkg::pm_winner_t  winner_i,
    output pm_pkg::pm_vec_t     pm_nom_o,
    output pm_pkg::pm_state_t   max_state_o
);

    import pm_pkg::*;

    localparam pm_metric_t SAT_MIN = pm_metric_t'(`PM_SAT_MIN);

    pm_metric_t pm_q [`PM_NUM_STATES];
    pm_state_t  max_state_q;

    genvar s;

    // ------------------------------
    // Metric registers
    // ------------------------------
    for (s = 0; s < `PM_NUM_STATES; s++) begin : g_state
        logic signed [`PM_WIDTH:0] diff;
        pm_metric_t                sat;
        pm_metric_t                init;

        // One extra bit so the difference never wraps
        assign diff = $signed({pm_i[s][`PM_WIDTH-1], pm_i[s]}) -
                      $signed({winner_i.metric[`PM_WIDTH-1], winner_i.metric});
        // Never positive for an active state, so only the low side clamps
        assign sat  = (diff < `PM_SAT_MIN) ? SAT_MIN : pm_metric_t'(diff);
        assign init = (cfg_i.tail_biting || s == 0) ? pm_metric_t'(0) : SAT_MIN;

        always_ff @(posedge clk_i or negedge rst_an_i) begin
            if (!rst_an_i) begin
                pm_q[s] <= '0;
            end else if (rst_sync_i) begin
                pm_q[s] <= '0;
            end else if (frame_start_i) begin
                pm_q[s] <= init;
            end else if (en_i && cfg_i.mask[s]) begin
                pm_q[s] <= sat;
            end
        end

        assign pm_nom_o[s] = pm_q[s];

        a_inactive_hold: assert property (@(posedge clk_i) disable iff (!rst_an_i)
            en_i && !rst_sync_i && !frame_start_i && !cfg_i.mask[s]
            |=> $stable(pm_q[s]));
    end

    // ------------------------------
    // Winner index
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_an_i) begin
        if (!rst_an_i) begin
            max_state_q <= '0;
        end else if (rst_sync_i) begin
            max_state_q <= '0;
        end else if (en_i && !frame_start_i) begin
            max_state_q <= winner_i.state;
        end
    end

    assign max_state_o = max_state_q;

endmodule

// ==== hdl/pm_norm_top.sv ====
`timescale 1ns/100ps

module pm_norm_top (
    input  logic                clk_i,
    input  logic                rst_an_i,
    input  logic                rst_sync_i,
    input  logic                frame_start_i,
    input  logic                en_i,
    input  pm_pkg::pm_vec_t     pm_i,
    input  pm_pkg::axil_req_t   axil_req_i,
    output pm_pkg::axil_rsp_t   axil_rsp_o,
    output pm_pkg::pm_vec_t     pm_nom_o,
    output pm_pkg::pm_state_t   max_state_o
);

    import pm_pkg::*;

    pm_cfg_t    cfg;
    pm_winner_t winner;

    // Mode, tail biting and status readback
    pm_cfg_regs u_cfg_regs (
        .clk_i       (clk_i),
        .rst_an_i    (rst_an_i),
        .axil_req_i  (axil_req_i),
        .axil_rsp_o  (axil_rsp_o),
        .max_state_i (max_state_o),
        .cfg_o       (cfg)
    );

    pm_max_tree u_max_tree (
        .pm_i     (pm_i),
        .cfg_i    (cfg),
        .winner_o (winner)
    );

    pm_normalizer u_normalizer (
        .clk_i         (clk_i),
        .rst_an_i      (rst_an_i),
        .rst_sync_i    (rst_sync_i),
        .frame_start_i (frame_start_i),
        .en_i          (en_i),
        .pm_i          (pm_i),
        .cfg_i         (cfg),
        .winner_i      (winner),
        .pm_nom_o      (pm_nom_o),
        .max_state_o   (max_state_o)
    );

endmodule

// ==== dv/tb_pm_norm.sv ====
`timescale 1ns/100ps
`include "pm_defines.svh"

module tb_pm_norm;

    import pm_pkg::*;

    // Well above the roughly 200 cycles the tests take
    localparam int TIMEOUT_CYCLES = 5000;

    logic       clk_i;
    logic       rst_an_i;
    logic       rst_sync_i;
    logic       frame_start_i;
    logic       en_i;
    pm_vec_t    pm_i;
    axil_req_t  axil_req;
    axil_rsp_t  axil_rsp;
    pm_vec_t    pm_nom_o;
    pm_state_t  max_state_o;

    int seed = 38247;
    int cycles = 0;
    int exp_pm [`PM_NUM_STATES];
    int exp_state;
    int cur_mode;

    pm_norm_top dut (
        .clk_i         (clk_i),
        .rst_an_i      (rst_an_i),
        .rst_sync_i    (rst_sync_i),
        .frame_start_i (frame_start_i),
        .en_i          (en_i),
        .pm_i          (pm_i),
        .axil_req_i    (axil_req),
        .axil_rsp_o    (axil_rsp),
        .pm_nom_o      (pm_nom_o),
        .max_state_o   (max_state_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("FAIL @ %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic pm_vec_t random_vec(input int n, input bit tie);
        pm_vec_t v;
        int      a;
        int      b;
        for (int s = 0; s < `PM_NUM_STATES; s++) begin
            v[s] = pm_metric_t'($random(seed) % 200);
        end
        if (tie) begin
            a = rand_below(n - 1);
            b = a + 1 + rand_below(n - 1 - a);
            v[a] = pm_metric_t'(230);
            v[b] = pm_metric_t'(230);
        end
        // Bait above every active metric
        if (n < `PM_NUM_STATES) begin
            v[n + rand_below(`PM_NUM_STATES - n)] = pm_metric_t'(250);
        end
        return v;
    endfunction

    function automatic void model_step(input pm_vec_t vec);
        int n;
        int best;
        int d;
        n = `PM_NUM_STATES >> cur_mode;
        best = 0;
        for (int s = 1; s < n; s++) begin
            if ($signed(vec[s]) > $signed(vec[best])) begin
                best = s;
            end
        end
        exp_state = best;
        for (int s = 0; s < n; s++) begin
            d = int'($signed(vec[s])) - int'($signed(vec[best]));
            exp_pm[s] = (d < `PM_SAT_MIN) ? `PM_SAT_MIN : d;
        end
    endfunction

    function automatic void model_frame(input int tb);
        for (int s = 0; s < `PM_NUM_STATES; s++) begin
            exp_pm[s] = (tb != 0 || s == 0) ? 0 : `PM_SAT_MIN;
        end
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < `PM_NUM_STATES; s++) begin
            exp_pm[s] = 0;
        end
        exp_state = 0;
    endfunction

    task automatic check_outputs(input string tag);
        for (int s = 0; s < `PM_NUM_STATES; s++) begin
            check(32'($signed(pm_nom_o[s])), exp_pm[s], $sformatf("%s, state %0d", tag, s));
        end
        check(32'(max_state_o), exp_state, $sformatf("%s, winner index", tag));
    endtask

    // ------------------------------
    // Bus and pin drivers
    // ------------------------------
    task automatic axil_write(input logic [`PM_AXIL_ADDR_W-1:0] addr,
                              input logic [31:0] data, input logic [3:0] strb,
                              input int resp_delay);
        @(posedge clk_i);
        axil_req.awvalid <= 1'b1;
        axil_req.awaddr  <= addr;
        axil_req.wvalid  <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= strb;
        @(negedge clk_i);
        while (!axil_rsp.awready) @(negedge clk_i);
        check(32'(axil_rsp.wready), 1, "wready together with awready");
        @(posedge clk_i);
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        @(negedge clk_i);
        while (!axil_rsp.bvalid) @(negedge clk_i);
        check(32'(axil_rsp.bresp), 0, "write response");
        repeat (resp_delay) @(posedge clk_i);
        @(posedge clk_i);
        axil_req.bready <= 1'b1;
        @(posedge clk_i);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [`PM_AXIL_ADDR_W-1:0] addr,
                             output logic [31:0] data, input int resp_delay);
        @(posedge clk_i);
        axil_req.arvalid <= 1'b1;
        axil_req.araddr  <= addr;
        @(negedge clk_i);
        while (!axil_rsp.arready) @(negedge clk_i);
        @(posedge clk_i);
        axil_req.arvalid <= 1'b0;
        @(negedge clk_i);
        while (!axil_rsp.rvalid) @(negedge clk_i);
        data = axil_rsp.rdata;
        check(32'(axil_rsp.rresp), 0, "read response");
        repeat (resp_delay) @(posedge clk_i);
        @(posedge clk_i);
        axil_req.rready <= 1'b1;
        @(posedge clk_i);
        axil_req.rready <= 1'b0;
    endtask

    task automatic set_cfg(input int mode, input int tb);
        cur_mode = mode;
        axil_write(`PM_REG_CFG, (tb << 4) | mode, 4'h1, mode);
    endtask

    task automatic apply_one(input pm_vec_t vec, input string tag);
        @(posedge clk_i);
        pm_i <= vec;
        en_i <= 1'b1;
        @(posedge clk_i);
        en_i <= 1'b0;
        model_step(vec);
        @(negedge clk_i);
        check_outputs(tag);
    endtask

    task automatic pulse_ctrl(input logic clear, input logic fstart, input string tag);
        @(posedge clk_i);
        rst_sync_i    <= clear;
        frame_start_i <= fstart;
        @(posedge clk_i);
        rst_sync_i    <= 1'b0;
        frame_start_i <= 1'b0;
        @(negedge clk_i);
        check_outputs(tag);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset();
        logic [31:0] data;
        model_clear();
        check_outputs("after reset");
        axil_read(`PM_REG_CFG, data, 0);
        check(data, 0, "CFG after reset");
        axil_read(`PM_REG_STATUS, data, 1);
        check(data, 0, "STATUS after reset");
    endtask

    task automatic test_registers();
        logic [31:0] data;
        axil_write(`PM_REG_CFG, 32'hffff_ff13, 4'hf, 2);
        axil_read(`PM_REG_CFG, data, 3);
        check(data, 32'h13, "CFG readback");
        // Byte 0 not enabled
        axil_write(`PM_REG_CFG, 32'h0000_0002, 4'he, 0);
        axil_read(`PM_REG_CFG, data, 0);
        check(data, 32'h13, "CFG write without wstrb bit 0");
        axil_write(`PM_REG_STATUS, 32'h3f, 4'hf, 1);
        axil_read(`PM_REG_STATUS, data, 0);
        check(data, exp_state, "STATUS after write");
        axil_read(4'h8, data, 2);
        check(data, 0, "unmapped address");
        set_cfg(0, 0);
    endtask

    task automatic test_full_mode();
        pm_vec_t vec;
        pm_vec_t prev;
        vec = '0;
        prev = '0;
        // Output of vector i-1 is checked in the cycle vector i goes in
        for (int i = 0; i <= 20; i++) begin
            @(posedge clk_i);
            if (i > 0) begin
                model_step(prev);
            end
            if (i < 20) begin
                vec = random_vec(`PM_NUM_STATES, (i % 3) == 0);
                pm_i <= vec;
                en_i <= 1'b1;
            end else begin
                en_i <= 1'b0;
            end
            @(negedge clk_i);
            if (i > 0) begin
                check_outputs($sformatf("64 states, vector %0d", i - 1));
            end
            prev = vec;
        end
    endtask

    task automatic test_narrow_modes();
        logic [31:0] data;
        for (int mode = 3; mode >= 2; mode--) begin
            set_cfg(mode, 0);
            for (int k = 0; k < 4; k++) begin
                apply_one(random_vec(`PM_NUM_STATES >> mode, k == 1),
                          $sformatf("mode %0d, vector %0d", mode, k));
                axil_read(`PM_REG_STATUS, data, k);
                check(data, exp_state, $sformatf("mode %0d, STATUS %0d", mode, k));
            end
        end
    endtask

    task automatic test_frame_and_clear();
        logic [31:0] data;
        set_cfg(0, 0);
        model_frame(0);
        pulse_ctrl(1'b0, 1'b1, "frame start");
        set_cfg(0, 1);
        model_frame(1);
        pulse_ctrl(1'b0, 1'b1, "frame start with tail biting");
        // Without tail biting a frame start would leave -128 behind
        set_cfg(1, 0);
        apply_one(random_vec(`PM_NUM_STATES >> 1, 1'b0), "before clear");
        model_clear();
        pulse_ctrl(1'b1, 1'b1, "clear with frame start");
        axil_read(`PM_REG_CFG, data, 0);
        check(data, 32'h01, "CFG kept over clear");
    endtask

    initial begin
        rst_an_i      = 1'b0;
        rst_sync_i    = 1'b0;
        frame_start_i = 1'b0;
        en_i          = 1'b0;
        pm_i          = '0;
        axil_req      = '0;
        cur_mode      = 0;
        repeat (3) @(posedge clk_i);
        rst_an_i <= 1'b1;
        @(negedge clk_i);
        test_reset();
        test_registers();
        test_full_mode();
        test_narrow_modes();
        test_frame_and_clear();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/pm_pkg.sv
hdl/pm_cfg_regs.sv
hdl/pm_max_tree.sv
hdl/pm_normalizer.sv
hdl/pm_norm_top.sv
dv/tb_pm_norm.sv

// ==== Makefile ====
SRCS := tb.f $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_pm_norm: $(SRCS)
	verilator --binary --timing --assert -j 0 -f tb.f --top-module tb_pm_norm -o Vtb_pm_norm

run: obj_dir/Vtb_pm_norm
	./obj_dir/Vtb_pm_norm

clean:
	rm -rf obj_dir
